//--- instr_dec.f
+incdir+verilog
+incdir+tb
verilog/instr_dec_pkg.sv
verilog/instr_reg.sv
verilog/op_decode.sv
verilog/cond_eval.sv
verilog/cycle_seq.sv
verilog/instr_dec_top.sv
tb/instr_dec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module instr_dec_tb -f instr_dec.f \
	-o instr_dec_sim > build.log 2>&1 && ./obj_dir/instr_dec_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log 2>/dev/null && exit 1
grep -q "RESULT: PASS" sim.log 2>/dev/null && exit 0 || exit 1

//--- tb/instr_dec_model.svh
`ifndef INSTR_DEC_MODEL_SVH
`define INSTR_DEC_MODEL_SVH

// Normal opcode 020-057 with zero C field, next word is the argument
function automatic bit needs_arg(input logic [0:`ID_WORD_W-1] w);
	return (w[`ID_OP_MSB:`ID_OP_LSB] >= 6'o20) && (w[`ID_OP_MSB:`ID_OP_LSB] <= 6'o57) &&
	       (w[`ID_C_MSB:`ID_C_LSB] == 3'd0);
endfunction

function automatic instr_dec_pkg::exec_rec_t expect_rec(
	input logic [0:`ID_WORD_W-1]   w,	// Instruction word
	input logic [0:`ID_WORD_W-1]   arg,	// Following word, if any
	input logic                    um,	// User mode q
	input instr_dec_pkg::r0_flags_t f
);
	instr_dec_pkg::exec_rec_t r;
	logic [5:0]               op;	// Opcode as a number
	logic [2:0]               a;	// Condition select
	logic                     hit;	// Jump condition met
	op = w[`ID_OP_MSB:`ID_OP_LSB];
	a  = w[`ID_A_MSB:`ID_A_LSB];
	r = '0;
	r.ir = w;
	if (op < 6'o20 || op > 6'o73)
		r.op_class = instr_dec_pkg::CLS_ILL;	// 000-017, 074-077
	else if (op <= 6'o57)
		r.op_class = instr_dec_pkg::CLS_NORM;
	else if (op <= 6'o67)
		r.op_class = instr_dec_pkg::CLS_KA1;
	else if (op == 6'o70)
		r.op_class = instr_dec_pkg::CLS_J;
	else if (op == 6'o71)
		r.op_class = instr_dec_pkg::CLS_JS;
	else if (op == 6'o72)
		r.op_class = instr_dec_pkg::CLS_C;
	else
		r.op_class = instr_dec_pkg::CLS_S;
	r.alu_mode = ((op >= 6'o20 && op <= 6'o37) || r.op_class == instr_dec_pkg::CLS_KA1) ?
	             instr_dec_pkg::ALU_ARYT : instr_dec_pkg::ALU_LOGIC;
	r.xi = (r.op_class == instr_dec_pkg::CLS_ILL) ||
	       (r.op_class == instr_dec_pkg::CLS_S && um) ||	// System op in user mode
	       (r.op_class == instr_dec_pkg::CLS_C && w[`ID_B_MSB:`ID_B_LSB] != 3'd0);
	case (a)
		3'd0:    hit = (r.op_class == instr_dec_pkg::CLS_J);	// JS with A=0 never jumps
		3'd1:    hit = f.l;
		3'd2:    hit = f.e;
		3'd3:    hit = f.g;
		3'd4:    hit = f.v;
		3'd5:    hit = f.x;
		3'd6:    hit = f.y;
		default: hit = f.c;
	endcase
	r.nef = r.xi || (!hit && (r.op_class == instr_dec_pkg::CLS_J ||
	                          r.op_class == instr_dec_pkg::CLS_JS));
	if (!r.nef) begin
		case (r.op_class)
			instr_dec_pkg::CLS_NORM: r.cycles = needs_arg(w) ? 3'd2 : 3'd1;	// P4 WE or WE
			instr_dec_pkg::CLS_C:    r.cycles = 3'd2;	// WS WX
			instr_dec_pkg::CLS_S:    r.cycles = 3'd2;	// WX WM
			default:                 r.cycles = 3'd1;	// KA1 WS, jumps WP
		endcase
	end
	if (needs_arg(w))
		r.arg = arg;
	return r;
endfunction

`endif

//--- tb/instr_dec_tb.sv
`timescale 1ns/1ps
`include "instr_dec_defs.svh"

module instr_dec_tb;
	localparam int N_TESTS     = 5;
	localparam int MAX_WORDS   = 300;	// Longest test
	localparam int CYCLE_LIMIT = N_TESTS * MAX_WORDS * 12;

	logic                     clk_sys;
	logic                     arst_n;
	logic                     word_valid;
	logic [0:`ID_WORD_W-1]    word;
	logic                     word_credit;
	logic                     invalidate;
	logic                     q;
	instr_dec_pkg::r0_flags_t r0;
	logic                     rec_valid;
	instr_dec_pkg::exec_rec_t rec;
	logic                     rec_credit;

	integer                   seed;
	instr_dec_pkg::exec_rec_t exp_q [$];	// Records the DUT still owes
	int                       src_credits;	// Source side credit count
	int                       held;	// Records held by the consumer
	int                       ret_pct;	// Credit return chance per cycle
	int                       errors;
	int                       recs;
	int                       words_sent;
	int                       cycles;
	int                       test_words;
	int                       test_recs;
	int                       test_errs;
	logic [0:`ID_WORD_W-1]    pend_ir;	// Instruction waiting for its argument
	bit                       pend_arg;

	`include "instr_dec_model.svh"

	instr_dec_top instr_dec_top_inst (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.word_valid  (word_valid),
		.word        (word),
		.word_credit (word_credit),
		.invalidate  (invalidate),
		.q           (q),
		.r0          (r0),
		.rec_valid   (rec_valid),
		.rec         (rec),
		.rec_credit  (rec_credit)
	);

	always #50 clk_sys = ~clk_sys;	// 100 ns period

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, DUT stopped producing records", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic bit chance(input int pct);
		int r;
		r = $random(seed);
		return ((r & 32'h7fffffff) % 100) < pct;
	endfunction

	task automatic random_flags();
		logic [31:0] r;
		r = $random(seed);
		r0 = r[8:0];
	endtask

	task automatic send_word(input int kind);
		logic [31:0]           r;
		logic [0:`ID_WORD_W-1] w;
		r = $random(seed);
		w = r[15:0];
		if (pend_arg) begin
			exp_q.push_back(expect_rec(pend_ir, w, q, r0));	// Argument, no record
			pend_arg = 1'b0;
		end else begin
			case (kind)
				1: w[`ID_OP_MSB:`ID_OP_LSB] = 6'o70 | {5'd0, r[16]};	// J or JS
				2: w[`ID_OP_MSB:`ID_OP_LSB] = 6'o72 | {5'd0, r[16]};	// C or S group
				3: begin	// Normal, argument follows
					w[`ID_OP_MSB:`ID_OP_LSB] = 6'o20 + {1'b0, r[20:16]};
					w[`ID_C_MSB:`ID_C_LSB]   = 3'd0;
				end
				4: begin	// JS never taken
					w[`ID_OP_MSB:`ID_OP_LSB] = 6'o71;
					w[`ID_A_MSB:`ID_A_LSB]   = 3'd0;
				end
				default: ;
			endcase
			if (needs_arg(w)) begin
				pend_ir  = w;
				pend_arg = 1'b1;
			end else begin
				exp_q.push_back(expect_rec(w, '0, q, r0));
			end
		end
		word        = w;
		word_valid  = 1'b1;
		src_credits = src_credits - 1;
		words_sent  = words_sent + 1;
	endtask

	task automatic check_record();
		instr_dec_pkg::exec_rec_t exp;
		assert (exp_q.size() > 0) else begin
			$display("Record with ir %h arrived at %0t with none outstanding", rec.ir, $time);
			errors++;
		end
		if (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			assert (rec == exp) else begin
				$display("Fail at %0t: ir %h got %h expected %h", $time, exp.ir, rec, exp);
				errors++;
			end
		end
		held = held + 1;
		recs = recs + 1;
		assert (held <= `ID_OUT_CREDITS) else begin
			$display("Consumer holds %0d records at %0t, above its capacity", held, $time);
			errors++;
		end
	endtask

	// One clock: sample outputs, then drive inputs 1 ns after the edge
	task automatic cycle_step(input bit send_en, input int kind);
		@(posedge clk_sys);
		#1;
		if (word_credit)
			src_credits = src_credits + 1;
		assert (src_credits <= `ID_IN_CREDITS) else begin
			$display("Source got more credits back than it spent at %0t", $time);
			errors++;
		end
		if (rec_valid)
			check_record();
		rec_credit = (held > 0) && chance(ret_pct);
		if (rec_credit)
			held = held - 1;
		word_valid = 1'b0;
		if (send_en && src_credits > 0 && chance(70))
			send_word(kind);
	endtask

	task automatic send_words(input int n, input int kind);
		int start;
		start = words_sent;
		while (words_sent - start < n || pend_arg)
			cycle_step(1'b1, kind);
	endtask

	task automatic drain();
		while (exp_q.size() > 0)
			cycle_step(1'b0, 0);
	endtask

	task automatic start_test();
		test_words = words_sent;
		test_recs  = recs;
		test_errs  = errors;
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %0d words, %0d records, %0d errors", num, name,
		         words_sent - test_words, recs - test_recs, errors - test_errs);
	endtask

	initial begin
		int i;
		clk_sys     = 1'b0;
		arst_n      = 1'b0;
		word_valid  = 1'b0;
		word        = '0;
		invalidate  = 1'b0;
		q           = 1'b0;
		r0          = '0;
		rec_credit  = 1'b0;
		seed        = 32'hafee;
		src_credits = `ID_IN_CREDITS;
		held        = 0;
		ret_pct     = 80;
		errors      = 0;
		recs        = 0;
		words_sent  = 0;
		cycles      = 0;
		pend_ir     = '0;
		pend_arg    = 1'b0;
		repeat (4) @(posedge clk_sys);
		assert (!word_credit && !rec_valid) else begin
			$display("Credit or record strobe active during reset at %0t", $time);
			errors++;
		end
		#1 arst_n = 1'b1;

		start_test();	// Mixed words, supervisor mode
		random_flags();
		send_words(MAX_WORDS, 0);
		drain();
		finish_test(1, "random words q=0");

		start_test();	// Fresh R0 for every jump
		for (i = 0; i < 64; i++) begin
			random_flags();
			send_words(1, (i % 8 == 0) ? 4 : 1);
			drain();
		end
		finish_test(2, "jump conditions");

		start_test();
		q = 1'b1;	// S group illegal in user mode
		random_flags();
		send_words(40, 2);
		drain();
		q = 1'b0;
		send_words(40, 2);
		drain();
		finish_test(3, "C and S groups");

		start_test();
		send_words(60, 3);	// Half the words are arguments
		drain();
		finish_test(4, "argument words");

		start_test();
		ret_pct = 15;	// Slow consumer
		random_flags();
		send_words(200, 0);
		drain();
		ret_pct = 80;
		finish_test(5, "consumer back-pressure");

		$display("tests %0d, words %0d, records %0d, errors %0d", N_TESTS, words_sent, recs,
		         errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- verilog/instr_dec_top.sv
`timescale 1ns/1ps
`include "instr_dec_defs.svh"

module instr_dec_top (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      word_valid,	// Fetch source word strobe
	input  logic [0:`ID_WORD_W-1]     word,
	output logic                      word_credit,	// Credit back to source
	input  logic                      invalidate,	// Drop IR contents
	input  logic                      q,	// User mode
	input  instr_dec_pkg::r0_flags_t  r0,
	output logic                      rec_valid,
	output instr_dec_pkg::exec_rec_t  rec,
	input  logic                      rec_credit	// Consumer slot freed
);
	logic [0:`ID_WORD_W-1] ir;
	logic                  ir_valid;
	logic [0:`ID_WORD_W-1] arg_word;
	logic                  arg_avail;
	logic                  ir_done;
	logic                  arg_take;
	instr_dec_pkg::dec_t   dec;
	logic                  nef;

	instr_reg instr_reg_inst (	// Queue and IR
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.word_valid  (word_valid),
		.word        (word),
		.invalidate  (invalidate),
		.ir_done     (ir_done),
		.arg_take    (arg_take),
		.ir          (ir),
		.ir_valid    (ir_valid),
		.arg_word    (arg_word),
		.arg_avail   (arg_avail),
		.word_credit (word_credit)
	);

	op_decode op_decode_inst (
		.ir       (ir),
		.ir_valid (ir_valid),
		.q        (q),
		.dec      (dec)
	);

	cond_eval cond_eval_inst (	// Jump conditions and nef
		.dec (dec),
		.r0  (r0),
		.nef (nef)
	);

	cycle_seq cycle_seq_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dec        (dec),
		.nef        (nef),
		.ir_valid   (ir_valid),
		.arg_word   (arg_word),
		.arg_avail  (arg_avail),
		.rec_credit (rec_credit),
		.ir_done    (ir_done),
		.arg_take   (arg_take),
		.rec_valid  (rec_valid),
		.rec        (rec)
	);

endmodule

//--- verilog/cycle_seq.sv
`timescale 1ns/1ps
`include "instr_dec_defs.svh"

module cycle_seq (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  instr_dec_pkg::dec_t       dec,
	input  logic                      nef,
	input  logic                      ir_valid,
	input  logic [0:`ID_WORD_W-1]     arg_word,	// Queue head
	input  logic                      arg_avail,
	input  logic                      rec_credit,	// Consumer frees one slot
	output logic                      ir_done,
	output logic                      arg_take,
	output logic                      rec_valid,
	output instr_dec_pkg::exec_rec_t  rec
);
	localparam int CRD_W = $clog2(`ID_OUT_CREDITS + 1);

	instr_dec_pkg::exec_state_e state;
	instr_dec_pkg::exec_state_e state_nxt;
	instr_dec_pkg::exec_state_e first_st;	// Entry state for the class
	logic [CRD_W-1:0]           credit_cnt;	// Free consumer slots
	logic [2:0]                 cyc_cnt;	// States walked so far
	logic [0:`ID_WORD_W-1]      arg_q;

	always_comb begin
		first_st = instr_dec_pkg::ST_KC;	// Illegal or ineffective end at once
		if (!nef) begin
			case (dec.op_class)
				instr_dec_pkg::CLS_NORM:
					first_st = dec.c0 ? instr_dec_pkg::ST_P4 : instr_dec_pkg::ST_WE;
				instr_dec_pkg::CLS_KA1: first_st = instr_dec_pkg::ST_WS;
				instr_dec_pkg::CLS_J:   first_st = instr_dec_pkg::ST_WP;
				instr_dec_pkg::CLS_JS:  first_st = instr_dec_pkg::ST_WP;
				instr_dec_pkg::CLS_C:   first_st = instr_dec_pkg::ST_WS;
				instr_dec_pkg::CLS_S:   first_st = instr_dec_pkg::ST_WX;
				default:                first_st = instr_dec_pkg::ST_KC;
			endcase
		end
	end

	// Record out only with a free slot and a live IR
	assign rec_valid = (state == instr_dec_pkg::ST_KC) & ir_valid & (credit_cnt != '0);
	assign ir_done   = rec_valid;
	assign arg_take  = (state == instr_dec_pkg::ST_P4) & arg_avail;

	always_comb begin
		state_nxt = state;
		case (state)
			instr_dec_pkg::ST_IDLE:
				if (ir_valid)
					state_nxt = first_st;
			instr_dec_pkg::ST_P4:
				if (arg_avail)
					state_nxt = instr_dec_pkg::ST_WE;	// Argument captured
			instr_dec_pkg::ST_WS:	// KA1 ends here and C group goes on
				state_nxt = (dec.op_class == instr_dec_pkg::CLS_C) ?
				            instr_dec_pkg::ST_WX : instr_dec_pkg::ST_KC;
			instr_dec_pkg::ST_WX:	// S group continues to WM
				state_nxt = (dec.op_class == instr_dec_pkg::CLS_S) ?
				            instr_dec_pkg::ST_WM : instr_dec_pkg::ST_KC;
			instr_dec_pkg::ST_KC:
				if (rec_valid)
					state_nxt = instr_dec_pkg::ST_IDLE;
			default:
				state_nxt = instr_dec_pkg::ST_KC;	// WE WP and WM
		endcase
		if (state != instr_dec_pkg::ST_IDLE && !ir_valid)
			state_nxt = instr_dec_pkg::ST_IDLE;	// Abort on invalidated IR
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= instr_dec_pkg::ST_IDLE;
			cyc_cnt    <= '0;
			credit_cnt <= CRD_W'(`ID_OUT_CREDITS);
		end else begin
			state <= state_nxt;
			if (state == instr_dec_pkg::ST_IDLE)
				cyc_cnt <= '0;
			else if (state != instr_dec_pkg::ST_KC && state_nxt != state)
				cyc_cnt <= cyc_cnt + 3'd1;	// Count each state once
			case ({rec_valid, rec_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == instr_dec_pkg::ST_IDLE)
			arg_q <= '0;	// No argument unless P4 runs
		else if (arg_take)
			arg_q <= arg_word;
	end

	always_comb begin
		rec.ir       = dec.ir;
		rec.arg      = arg_q;
		rec.op_class = dec.op_class;
		rec.alu_mode = dec.alu_mode;
		rec.xi       = dec.xi;
		rec.nef      = nef;
		rec.cycles   = cyc_cnt;
	end

	// Consumer never returns more credits than it was given
	a_credit_bound: assert property (@(posedge clk_sys) disable iff (!arst_n)
		credit_cnt <= CRD_W'(`ID_OUT_CREDITS));

	// Stalled KC keeps the IR and so the record
	a_stall_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(state == instr_dec_pkg::ST_KC && ir_valid && !rec_valid) |=> $stable(rec.ir));

endmodule

//--- verilog/cond_eval.sv
`timescale 1ns/1ps
`include "instr_dec_defs.svh"

module cond_eval (
	input  instr_dec_pkg::dec_t      dec,
	input  instr_dec_pkg::r0_flags_t r0,	// Upper R0 flags
	output logic                     nef	// Instruction is ineffective
);
	logic [0:2] a_fld;	// Condition select
	logic       cond;	// Selected condition met
	logic       is_jump;

	assign a_fld   = dec.ir[`ID_A_MSB:`ID_A_LSB];
	assign is_jump = (dec.op_class == instr_dec_pkg::CLS_J) |
	                 (dec.op_class == instr_dec_pkg::CLS_JS);

	always_comb begin
		case (a_fld)
			3'd0:    cond = (dec.op_class == instr_dec_pkg::CLS_J);	// JS never
			3'd1:    cond = r0.l;
			3'd2:    cond = r0.e;
			3'd3:    cond = r0.g;
			3'd4:    cond = r0.v;
			3'd5:    cond = r0.x;
			3'd6:    cond = r0.y;
			default: cond = r0.c;
		endcase
	end

	// Illegal implies ineffective, failed jump condition too
	assign nef = dec.xi | (is_jump & ~cond);

endmodule

//--- verilog/op_decode.sv
`timescale 1ns/1ps
`include "instr_dec_defs.svh"

module op_decode (
	input  logic                  [0:`ID_WORD_W-1] ir,
	input  logic                  ir_valid,
	input  logic                  q,	// User mode flag
	output instr_dec_pkg::dec_t   dec
);
	logic [0:5]                opc;	// Opcode, MSB first
	instr_dec_pkg::op_class_e  cls;
	logic                      b0;
	logic                      c0;
	logic                      xi_low;	// Opcode bits 0-1 zero
	logic                      xi_top;	// 074-077
	logic                      xi_user;	// S group in user mode
	logic                      xi_cgrp;	// C group with B modification
	logic                      aryt;

	assign opc = ir[`ID_OP_MSB:`ID_OP_LSB];
	assign b0  = (ir[`ID_B_MSB:`ID_B_LSB] == '0);
	assign c0  = (ir[`ID_C_MSB:`ID_C_LSB] == '0);

	always_comb begin
		cls = instr_dec_pkg::CLS_ILL;	// 000-017 stay illegal
		if (opc[0:1] != 2'b00) begin
			if (opc[0:1] != 2'b11) begin
				cls = instr_dec_pkg::CLS_NORM;	// 020-057
			end else if (!opc[2]) begin
				cls = instr_dec_pkg::CLS_KA1;	// 060-067
			end else begin
				case (opc[3:5])
					3'd0:    cls = instr_dec_pkg::CLS_J;
					3'd1:    cls = instr_dec_pkg::CLS_JS;
					3'd2:    cls = instr_dec_pkg::CLS_C;
					3'd3:    cls = instr_dec_pkg::CLS_S;
					default: cls = instr_dec_pkg::CLS_ILL;	// 074-077
				endcase
			end
		end
		if (!ir_valid)
			cls = instr_dec_pkg::CLS_ILL;	// Empty IR decodes as nothing
	end

	assign xi_low  = (opc[0:1] == 2'b00);
	assign xi_top  = (opc[0:3] == 4'b1111);
	assign xi_user = (cls == instr_dec_pkg::CLS_S) & q;
	assign xi_cgrp = (cls == instr_dec_pkg::CLS_C) & ~b0;

	// Arithmetic for 020-037 and KA1
	assign aryt = (opc[0:1] == 2'b01) | (cls == instr_dec_pkg::CLS_KA1);

	always_comb begin
		dec.ir       = ir;
		dec.op_class = cls;
		dec.b0       = b0;
		dec.c0       = c0;
		dec.xi       = ~ir_valid | xi_low | xi_top | xi_user | xi_cgrp;
		dec.alu_mode = aryt ? instr_dec_pkg::ALU_ARYT : instr_dec_pkg::ALU_LOGIC;
	end

endmodule

//--- verilog/instr_reg.sv
`timescale 1ns/1ps
`include "instr_dec_defs.svh"

module instr_reg (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  word_valid,	// Word from fetch source
	input  logic [0:`ID_WORD_W-1] word,
	input  logic                  invalidate,	// Drop IR contents
	input  logic                  ir_done,	// Sequencer releases the IR
	input  logic                  arg_take,	// Pop queue head as argument
	output logic [0:`ID_WORD_W-1] ir,
	output logic                  ir_valid,
	output logic [0:`ID_WORD_W-1] arg_word,
	output logic                  arg_avail,
	output logic                  word_credit	// One queue entry freed
);
	localparam int DEPTH = `ID_IN_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [0:`ID_WORD_W-1] fifo_mem [DEPTH];	// Word queue storage
	logic [PTR_W-1:0]      rd_ptr;
	logic [PTR_W-1:0]      wr_ptr;
	logic [CNT_W-1:0]      fifo_cnt;
	logic                  fifo_empty;
	logic                  fifo_full;
	logic                  ir_free;	// IR empty or released this cycle
	logic                  bypass;	// Straight into IR, queue empty
	logic                  load_head;	// IR loads from queue head
	logic                  push;
	logic                  pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign fifo_empty = (fifo_cnt == '0);
	assign fifo_full  = (fifo_cnt == CNT_W'(DEPTH));
	assign ir_free    = ~ir_valid | ir_done;
	assign bypass     = word_valid & fifo_empty & ir_free & ~invalidate;
	assign load_head  = ~fifo_empty & ir_free & ~invalidate;
	assign push       = word_valid & ~bypass;
	assign pop        = load_head | arg_take;	// Never both, IR busy in P4
	assign arg_word   = fifo_mem[rd_ptr];	// Head is the argument
	assign arg_avail  = ~fifo_empty;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr      <= '0;
			wr_ptr      <= '0;
			fifo_cnt    <= '0;
			ir_valid    <= 1'b0;
			word_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
				2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
			if (invalidate)
				ir_valid <= 1'b0;	// Invalidate wins over everything
			else if (bypass | load_head)
				ir_valid <= 1'b1;
			else if (ir_done)
				ir_valid <= 1'b0;
			word_credit <= bypass | pop;	// Credit back one cycle later
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			fifo_mem[wr_ptr] <= word;
		if (bypass)
			ir <= word;
		else if (load_head)
			ir <= fifo_mem[rd_ptr];
	end

	// Source must hold a credit for every word it sends
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!arst_n)
		word_valid |-> !fifo_full);

	// Sequencer only takes an argument that is already queued
	a_arg_present: assert property (@(posedge clk_sys) disable iff (!arst_n)
		arg_take |-> arg_avail);

endmodule

//--- verilog/instr_dec_pkg.sv
`include "instr_dec_defs.svh"

package instr_dec_pkg;

	// Opcode class, from the six opcode bits
	typedef enum logic [2:0] {
		CLS_ILL,	// 000-017 and 074-077
		CLS_NORM,	// 020-057, two-arg with normal argument
		CLS_KA1,	// 060-067
		CLS_J,		// 070 jumps
		CLS_JS,		// 071 short conditional jumps
		CLS_C,		// 072 shift and misc group
		CLS_S		// 073 system group
	} op_class_e;

	typedef enum logic {
		ALU_LOGIC,	// Logic operation mode
		ALU_ARYT	// Arithmetic mode
	} alu_mode_e;

	typedef enum logic [2:0] {
		ST_IDLE,	// Waiting for a valid IR
		ST_P4,		// Argument fetch
		ST_WS,		// W& state
		ST_WE,
		ST_WP,
		ST_WX,
		ST_WM,
		ST_KC		// Cycle end, record issue
	} exec_state_e;

	// Upper R0 bits, same order as R0[0:8]
	typedef struct packed {
		logic z;	// Zero
		logic m;	// Minus
		logic v;	// Overflow
		logic c;	// Carry
		logic l;	// Less
		logic e;	// Equal
		logic g;	// Greater
		logic y;	// Shift-out Y
		logic x;	// Shift-out X
	} r0_flags_t;

	typedef struct packed {
		logic [0:`ID_WORD_W-1] ir;	// Raw IR word
		op_class_e             op_class;
		logic                  b0;	// B==0
		logic                  c0;	// C==0, argument follows
		logic                  xi;	// Illegal
		alu_mode_e             alu_mode;
	} dec_t;

	typedef struct packed {
		logic [0:`ID_WORD_W-1] ir;
		logic [0:`ID_WORD_W-1] arg;	// Zero unless normal with C==0
		op_class_e             op_class;
		alu_mode_e             alu_mode;
		logic                  xi;
		logic                  nef;	// Ineffective
		logic [2:0]            cycles;	// States walked before KC
	} exec_rec_t;

endpackage

//--- verilog/instr_dec_defs.svh
`ifndef INSTR_DEC_DEFS_SVH
`define INSTR_DEC_DEFS_SVH

`define ID_WORD_W       16	// Instruction word width
`define ID_IN_CREDITS   2	// Input queue depth, source credits at reset
`define ID_OUT_CREDITS  2	// Records the consumer can hold

// Field positions, bit 0 is the MSB
`define ID_OP_MSB       0	// Opcode
`define ID_OP_LSB       5
`define ID_A_MSB        7	// A field, register or jump condition
`define ID_A_LSB        9
`define ID_B_MSB        10	// B field, B-modification register
`define ID_B_LSB        12
`define ID_C_MSB        13	// C field, zero means argument in next word
`define ID_C_LSB        15

`endif
